//--- list.f
rtl/spi_pkg.sv
rtl/byte_fifo.sv
rtl/spi_clk_div.sv
rtl/spi_tx_shifter.sv
rtl/spi_rx_shifter.sv
rtl/spi_regs.sv
rtl/sd_spi_top.sv
tb/tb_sd_spi.sv

//--- run.sh
#!/bin/sh
# build and run the SD SPI testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_sd_spi -f list.f

./obj_dir/Vtb_sd_spi > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    exit 1
fi
exit 0

//--- tb/tb_sd_spi.sv
//////////////////////////////
// testbench for the SD card SPI master
// MOSI looped back to MISO, register
// accesses through the request port
//////////////////////////////
`default_nettype none

module tb_sd_spi;

    import spi_pkg::*;

    typedef logic [7:0] byte_queue_t [$];

    localparam int n_transfers   = 5;
    localparam int max_bytes     = 9;      // 8 data bytes plus the crc7 byte
    localparam int max_scaler    = 4;
    localparam int watchdog_time = n_transfers * max_bytes * 16 * max_scaler * 10 + 20000;
    localparam logic [31:0] ctrl_idle_mask = 32'hFFFF_00B7;

    logic        i_clk;
    logic        i_nrst;
    logic        i_req_valid;
    logic [31:0] i_req_addr;
    logic        i_req_write;
    logic [31:0] i_req_wdata;
    logic        o_resp_valid;
    logic [31:0] o_resp_rdata;
    logic        o_cs;
    logic        o_sclk;
    logic        o_mosi;
    logic        i_detected;
    logic        i_protect;

    logic        chk_on;       // response of the last request is a read to compare
    logic [31:0] chk_mask;
    logic [31:0] chk_exp;
    string       chk_name;
    int          sclk_edges;
    int          exp_edges;
    byte_queue_t exp_q;        // bytes expected back through the loop

    sd_spi_top #(.log2_fifosz(4)) i_sd_spi_top (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_req_valid(i_req_valid),
        .i_req_addr(i_req_addr), .i_req_write(i_req_write), .i_req_wdata(i_req_wdata),
        .o_resp_valid(o_resp_valid), .o_resp_rdata(o_resp_rdata),
        .o_cs(o_cs), .o_sclk(o_sclk), .o_mosi(o_mosi), .i_miso(o_mosi),
        .i_detected(i_detected), .i_protect(i_protect)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    always @(posedge o_sclk) begin
        sclk_edges = sclk_edges + 1;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    a_resp_next: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_req_valid |=> o_resp_valid)
        else stop_on_error("FAILED o_resp_valid: expected 1, got 0");

    a_resp_quiet: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !i_req_valid |=> !o_resp_valid)
        else stop_on_error("FAILED o_resp_valid: expected 0, got 1");

    a_read_value: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (o_resp_valid && chk_on) |-> ((o_resp_rdata & chk_mask) == chk_exp))
        else stop_on_error($sformatf("FAILED o_resp_rdata (%s): expected %h, got %h",
            chk_name, chk_exp, $sampled(o_resp_rdata) & chk_mask));

    // pins stay quiet while the card is deselected
    a_idle_pins: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_cs |-> (!o_sclk && o_mosi))
        else stop_on_error($sformatf("FAILED o_sclk/o_mosi with o_cs high: got %h/%h",
            $sampled(o_sclk), $sampled(o_mosi)));

    // a deselect mid-transfer shows up as a short edge count
    a_edge_count: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $rose(o_cs) |-> (sclk_edges == exp_edges))
        else stop_on_error($sformatf("FAILED o_sclk rising edges: expected %h, got %h",
            exp_edges, $sampled(sclk_edges)));

    function automatic logic [6:0] crc7_over(input byte_queue_t data);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        foreach (data[i]) begin
            for (int k = 7; k >= 0; k--) begin
                fb  = crc[6] ^ data[i][k];
                crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);    // x^7 + x^3 + 1
            end
        end
        return crc;
    endfunction

    function automatic logic [15:0] crc16_over(input byte_queue_t data);
        logic [15:0] crc;
        logic        fb;
        crc = '0;
        foreach (data[i]) begin
            for (int k = 7; k >= 0; k--) begin
                fb  = crc[15] ^ data[i][k];
                crc = {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
            end
        end
        return crc;
    endfunction

    task automatic reg_write(input logic [9:0] word, input logic [31:0] data);
        @(negedge i_clk);
        chk_on      = 1'b0;
        i_req_valid = 1'b1;
        i_req_write = 1'b1;
        i_req_addr  = {20'h0, word, 2'b00};
        i_req_wdata = data;
        @(negedge i_clk);
        i_req_valid = 1'b0;
        i_req_write = 1'b0;
    endtask

    // expectation is held until the response has been sampled
    task automatic read_check(input logic [9:0] word, input logic [31:0] mask,
                              input logic [31:0] exp, input string name);
        @(negedge i_clk);
        chk_on      = 1'b1;
        chk_mask    = mask;
        chk_exp     = exp & mask;
        chk_name    = name;
        i_req_valid = 1'b1;
        i_req_write = 1'b0;
        i_req_addr  = {20'h0, word, 2'b00};
        i_req_wdata = '0;
        @(negedge i_clk);
        i_req_valid = 1'b0;
    endtask

    task automatic check_status();
        spi_ctrl_word_u exp_u;
        @(negedge i_clk);
        i_detected = 1'($urandom);
        i_protect  = 1'($urandom);
        exp_u            = '0;
        exp_u.rd.state   = st_idle;
        exp_u.rd.miso    = 1'b1;    // idle MOSI level through the loop
        exp_u.rd.protect = i_protect;
        exp_u.rd.detected = i_detected;
        read_check(addr_ctrl, ctrl_idle_mask, exp_u, "ctrl");
    endtask

    task automatic run_transfer(input int n_push, input int n_fill, input logic gen_crc);
        logic [31:0]    scaler;
        logic [7:0]     data;
        logic [6:0]     crc7;
        spi_ctrl_word_u ctrl_u;
        scaler = $urandom_range(max_scaler, 1);
        reg_write(addr_sckdiv, scaler);
        read_check(addr_sckdiv, 32'hFFFF_FFFF, scaler, "sckdiv");
        reg_write(addr_crc16, 32'h0);
        exp_q.delete();
        for (int i = 0; i < n_push; i++) begin
            data = 8'($urandom);
            reg_write(addr_txdata, {24'h0, data});
            exp_q.push_back(data);
        end
        for (int i = 0; i < n_fill; i++) begin
            exp_q.push_back(8'hFF);         // FIFO ran dry
        end
        if (gen_crc) begin
            crc7 = crc7_over(exp_q);
            exp_q.push_back({crc7, 1'b1});
        end
        exp_edges = sclk_edges + 8 * exp_q.size();
        ctrl_u            = '0;
        ctrl_u.wr.byte_count = 16'(n_push + n_fill);
        ctrl_u.wr.gen_crc = gen_crc;
        reg_write(addr_ctrl, ctrl_u);
        @(negedge o_cs);
        @(posedge o_cs);
        @(posedge i_clk);                   // state is idle one cycle after deselect
        check_status();
        foreach (exp_q[i]) begin
            read_check(addr_rxdata, 32'h8000_00FF, {24'h0, exp_q[i]}, "rxdata");
        end
        read_check(addr_rxdata, 32'h8000_0000, 32'h8000_0000, "rxdata empty");
        read_check(addr_crc16, 32'h0000_FFFF, {16'h0, crc16_over(exp_q)}, "crc16");
    endtask

    initial begin
        #(watchdog_time);
        stop_on_error("watchdog expired before the tests finished");
    end

    initial begin
        logic [15:0] seed16;
        void'($urandom(66));
        i_nrst      = 1'b0;
        i_req_valid = 1'b0;
        i_req_addr  = '0;
        i_req_write = 1'b0;
        i_req_wdata = '0;
        i_detected  = 1'b0;
        i_protect   = 1'b0;
        chk_on      = 1'b0;
        chk_mask    = '0;
        chk_exp     = '0;
        chk_name    = "";
        sclk_edges  = 0;
        exp_edges   = 0;
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_nrst = 1'b1;

        a_reset_pins: assert (o_cs === 1'b1 && o_sclk === 1'b0 && o_mosi === 1'b1)
            else stop_on_error($sformatf("FAILED o_cs/o_sclk/o_mosi after reset: got %h/%h/%h",
                o_cs, o_sclk, o_mosi));

        seed16 = 16'($urandom);
        reg_write(addr_crc16, {16'h0, seed16});
        read_check(addr_crc16, 32'h0000_FFFF, {16'h0, seed16}, "crc16");
        repeat (6) check_status();

        run_transfer($urandom_range(8, 1), 0, 1'b0);
        run_transfer($urandom_range(4, 1), $urandom_range(4, 1), 1'b0);
        run_transfer($urandom_range(8, 1), 0, 1'b1);
        run_transfer($urandom_range(4, 1), $urandom_range(4, 1), 1'b1);
        run_transfer($urandom_range(8, 1), 0, 1'b0);

        @(posedge i_clk);                   // last response gets sampled here
        @(negedge i_clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/sd_spi_top.sv
//////////////////////////////
// SD card SPI master, top level
// register port in, SPI pins out,
// divider, shifters and two FIFOs
//////////////////////////////
`default_nettype none

module sd_spi_top #(
    parameter int log2_fifosz = spi_pkg::log2_fifosz_def
) (
    input  wire logic        i_clk,
    input  wire logic        i_nrst,
    input  wire logic        i_req_valid,
    input  wire logic [31:0] i_req_addr,
    input  wire logic        i_req_write,
    input  wire logic [31:0] i_req_wdata,
    output logic             o_resp_valid,
    output logic      [31:0] o_resp_rdata,
    output logic             o_cs,
    output logic             o_sclk,
    output logic             o_mosi,
    input  wire logic        i_miso,
    input  wire logic        i_detected,
    input  wire logic        i_protect
);

    import spi_pkg::*;

    logic [31:0]          scaler;
    logic                 restart;
    logic                 level;
    logic                 rise;
    logic                 fall;
    logic                 load;
    logic [15:0]          byte_count;
    logic                 gen_crc;
    logic [15:0]          byte_count_now;
    logic                 gen_crc_now;
    spi_state_e           tx_state;
    logic                 cs_active;
    logic                 byte_end;
    logic                 tx_push;
    logic [7:0]           tx_wdata;
    logic                 tx_pop;
    logic [7:0]           tx_rdata;
    logic [log2_fifosz:0] tx_count;
    logic                 rx_push;
    logic [7:0]           rx_byte;
    logic                 rx_pop;
    logic [7:0]           rx_rdata;
    logic [log2_fifosz:0] rx_count;
    logic                 crc_wr;
    logic [15:0]          crc_wdata;
    logic [15:0]          crc16;

    assign o_cs   = !cs_active;           // active low on the pin
    assign o_sclk = level && cs_active;

    spi_clk_div u_clk_div (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_scaler(scaler), .i_restart(restart),
        .o_level(level), .o_rise(rise), .o_fall(fall)
    );

    spi_tx_shifter #(.log2_fifosz(log2_fifosz)) u_tx (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_rise(rise), .i_fall(fall),
        .i_load(load), .i_byte_count(byte_count), .i_gen_crc(gen_crc),
        .i_fifo_data(tx_rdata), .i_fifo_count(tx_count), .o_fifo_pop(tx_pop),
        .o_cs_active(cs_active), .o_byte_end(byte_end), .o_mosi(o_mosi),
        .o_byte_count_now(byte_count_now), .o_gen_crc_now(gen_crc_now),
        .o_state(tx_state)
    );

    spi_rx_shifter u_rx (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_rise(rise), .i_cs_active(cs_active),
        .i_byte_end(byte_end), .i_miso(i_miso), .i_crc_wr(crc_wr),
        .i_crc_wdata(crc_wdata), .o_push(rx_push), .o_rx_byte(rx_byte),
        .o_crc16(crc16)
    );

    spi_regs #(.log2_fifosz(log2_fifosz)) u_regs (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_req_valid(i_req_valid),
        .i_req_addr(i_req_addr), .i_req_write(i_req_write), .i_req_wdata(i_req_wdata),
        .o_resp_valid(o_resp_valid), .o_resp_rdata(o_resp_rdata),
        .o_scaler(scaler), .o_restart(restart), .o_load(load),
        .o_byte_count(byte_count), .o_gen_crc(gen_crc),
        .i_byte_count_now(byte_count_now), .i_gen_crc_now(gen_crc_now),
        .i_state(tx_state), .i_miso(i_miso), .i_detected(i_detected),
        .i_protect(i_protect), .o_tx_push(tx_push), .o_tx_wdata(tx_wdata),
        .i_tx_count(tx_count), .o_rx_pop(rx_pop), .i_rx_data(rx_rdata),
        .i_rx_count(rx_count), .o_crc_wr(crc_wr), .o_crc_wdata(crc_wdata),
        .i_crc16(crc16)
    );

    byte_fifo #(.log2_fifosz(log2_fifosz)) u_txfifo (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_we(tx_push), .i_wdata(tx_wdata),
        .i_re(tx_pop), .o_rdata(tx_rdata), .o_count(tx_count)
    );

    byte_fifo #(.log2_fifosz(log2_fifosz)) u_rxfifo (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_we(rx_push), .i_wdata(rx_byte),
        .i_re(rx_pop), .o_rdata(rx_rdata), .o_count(rx_count)
    );

endmodule

`default_nettype wire

//--- rtl/spi_regs.sv
//////////////////////////////
// SPI register block
// address decode, read mux, FIFO strobes
// and a registered response one cycle on
//////////////////////////////
`default_nettype none

module spi_regs #(
    parameter int log2_fifosz = spi_pkg::log2_fifosz_def
) (
    input  wire logic                 i_clk,
    input  wire logic                 i_nrst,
    input  wire logic                 i_req_valid,
    input  wire logic [31:0]          i_req_addr,
    input  wire logic                 i_req_write,
    input  wire logic [31:0]          i_req_wdata,
    output logic                      o_resp_valid,
    output logic      [31:0]          o_resp_rdata,
    output logic      [31:0]          o_scaler,
    output logic                      o_restart,
    output logic                      o_load,
    output logic      [15:0]          o_byte_count,
    output logic                      o_gen_crc,
    input  wire logic [15:0]          i_byte_count_now,
    input  wire logic                 i_gen_crc_now,
    input  wire spi_pkg::spi_state_e  i_state,
    input  wire logic                 i_miso,
    input  wire logic                 i_detected,
    input  wire logic                 i_protect,
    output logic                      o_tx_push,
    output logic      [7:0]           o_tx_wdata,
    input  wire logic [log2_fifosz:0] i_tx_count,
    output logic                      o_rx_pop,
    input  wire logic [7:0]           i_rx_data,
    input  wire logic [log2_fifosz:0] i_rx_count,
    output logic                      o_crc_wr,
    output logic      [15:0]          o_crc_wdata,
    input  wire logic [15:0]          i_crc16
);

    import spi_pkg::*;

    logic [9:0]     word_addr;
    logic           wr;
    logic           rd;
    logic [31:0]    scaler;
    logic [31:0]    rdata;
    spi_ctrl_word_u ctrl_in;
    spi_ctrl_word_u ctrl_out;

    assign word_addr = i_req_addr[11:2];
    assign wr        = i_req_valid && i_req_write;
    assign rd        = i_req_valid && !i_req_write;
    assign ctrl_in   = i_req_wdata;

    assign o_scaler     = scaler;
    assign o_restart    = wr && (word_addr == addr_sckdiv);
    assign o_load       = wr && (word_addr == addr_ctrl);
    assign o_byte_count = ctrl_in.wr.byte_count;
    assign o_gen_crc    = ctrl_in.wr.gen_crc;
    assign o_tx_push    = wr && (word_addr == addr_txdata);
    assign o_tx_wdata   = i_req_wdata[7:0];
    assign o_rx_pop     = rd && (word_addr == addr_rxdata);   // read pops the head
    assign o_crc_wr     = wr && (word_addr == addr_crc16);
    assign o_crc_wdata  = i_req_wdata[15:0];

    always_comb begin
        ctrl_out               = '0;
        ctrl_out.rd.byte_count = i_byte_count_now;
        ctrl_out.rd.gen_crc    = i_gen_crc_now;
        ctrl_out.rd.state      = i_state;
        ctrl_out.rd.miso       = i_miso;
        ctrl_out.rd.protect    = i_protect;
        ctrl_out.rd.detected   = i_detected;

        rdata = '0;
        case (word_addr)
            addr_sckdiv: rdata = scaler;
            addr_ctrl:   rdata = ctrl_out;
            addr_txdata: rdata[31] = i_tx_count[log2_fifosz];    // full
            addr_rxdata: begin
                rdata[7:0] = i_rx_data;
                rdata[31]  = (i_rx_count == '0);                 // empty
            end
            addr_crc16:  rdata[15:0] = i_crc16;
            default:     rdata = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            scaler       <= '0;
            o_resp_valid <= 1'b0;
        end else begin
            if (o_restart) scaler <= i_req_wdata;
            o_resp_valid <= i_req_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_resp_rdata <= rdata;
    end

endmodule

`default_nettype wire

//--- rtl/spi_rx_shifter.sv
//////////////////////////////
// SPI receiver
// samples MISO on rise strobes,
// assembles bytes, keeps CRC16
//////////////////////////////
`default_nettype none

module spi_rx_shifter (
    input  wire logic        i_clk,
    input  wire logic        i_nrst,
    input  wire logic        i_rise,
    input  wire logic        i_cs_active,
    input  wire logic        i_byte_end,
    input  wire logic        i_miso,
    input  wire logic        i_crc_wr,
    input  wire logic [15:0] i_crc_wdata,
    output logic             o_push,
    output logic      [7:0]  o_rx_byte,
    output logic      [15:0] o_crc16
);

    logic [7:0]  rx_shift;
    logic [15:0] crc16;
    logic        crc16_fb;
    logic [15:0] crc16_next;
    logic        sample;

    assign sample = i_rise && i_cs_active;

    // x^16 + x^12 + x^5 + 1
    assign crc16_fb   = crc16[15] ^ i_miso;
    assign crc16_next = {crc16[14:12], crc16[11] ^ crc16_fb, crc16[10:5],
                         crc16[4] ^ crc16_fb, crc16[3:0], crc16_fb};

    assign o_push    = i_byte_end;
    assign o_rx_byte = {rx_shift[6:0], i_miso};   // includes the bit sampled now
    assign o_crc16   = crc16;

    always_ff @(posedge i_clk) begin
        if (sample) rx_shift <= {rx_shift[6:0], i_miso};
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            crc16 <= '0;
        end else if (i_crc_wr) begin
            crc16 <= i_crc_wdata;    // software seed or clear
        end else if (sample) begin
            crc16 <= crc16_next;
        end
    end

    a_end_in_frame: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_byte_end |-> sample)
        else $error("spi_rx_shifter byte end outside a sample");

endmodule

`default_nettype wire

//--- rtl/spi_tx_shifter.sv
//////////////////////////////
// SPI transmitter
// chip select, byte counter, MOSI shifter
// and CRC7 over the sent bits
//////////////////////////////
`default_nettype none

module spi_tx_shifter #(
    parameter int log2_fifosz = spi_pkg::log2_fifosz_def
) (
    input  wire logic                 i_clk,
    input  wire logic                 i_nrst,
    input  wire logic                 i_rise,
    input  wire logic                 i_fall,
    input  wire logic                 i_load,
    input  wire logic [15:0]          i_byte_count,
    input  wire logic                 i_gen_crc,
    input  wire logic [7:0]           i_fifo_data,
    input  wire logic [log2_fifosz:0] i_fifo_count,
    output logic                      o_fifo_pop,
    output logic                      o_cs_active,
    output logic                      o_byte_end,
    output logic                      o_mosi,
    output logic      [15:0]          o_byte_count_now,
    output logic                      o_gen_crc_now,
    output spi_pkg::spi_state_e       o_state
);

    import spi_pkg::*;

    spi_state_e  state;
    logic        cs;
    logic [15:0] byte_cnt;
    logic [2:0]  bit_cnt;
    logic [7:0]  tx_val;      // next byte, loaded on the coming fall
    logic [7:0]  tx_shift;
    logic [6:0]  crc7;
    logic        gen_crc;
    logic        crc7_fb;
    logic [6:0]  crc7_next;
    logic        pending;
    logic        last_bit;

    // x^7 + x^3 + 1
    assign crc7_fb   = crc7[6] ^ tx_shift[7];
    assign crc7_next = {crc7[5:3], crc7[2] ^ crc7_fb, crc7[1:0], crc7_fb};

    assign pending    = (byte_cnt != '0);
    assign last_bit   = (state == st_send_data) && (bit_cnt == 3'd0) && i_rise;
    assign o_fifo_pop = pending && ((state == st_idle) || last_bit);
    assign o_byte_end = last_bit;

    assign o_cs_active      = cs;
    assign o_mosi           = tx_shift[7];
    assign o_byte_count_now = byte_cnt;
    assign o_gen_crc_now    = gen_crc;
    assign o_state          = state;

    always_ff @(posedge i_clk) begin
        if (o_fifo_pop) tx_val <= (i_fifo_count != '0) ? i_fifo_data : 8'hFF;
        else if (last_bit && gen_crc) tx_val <= {crc7_next, 1'b1};  // SD command tail
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state    <= st_idle;
            cs       <= 1'b0;
            byte_cnt <= '0;
            bit_cnt  <= '0;
            tx_shift <= '1;
            crc7     <= '0;
            gen_crc  <= 1'b0;
        end else begin
            if (i_fall && cs) begin
                tx_shift <= {tx_shift[6:0], 1'b1};
                if (bit_cnt != 3'd0) bit_cnt <= bit_cnt - 3'd1;
                else cs <= 1'b0;        // kept alive by wait_edge between bytes
            end
            if (i_rise && cs) crc7 <= crc7_next;

            case (state)
                st_idle: begin
                    if (pending) begin
                        byte_cnt <= byte_cnt - 16'd1;
                        crc7     <= '0;
                        state    <= st_wait_edge;
                    end
                end
                st_wait_edge: begin
                    if (i_fall) begin
                        cs       <= 1'b1;
                        bit_cnt  <= 3'd7;
                        tx_shift <= tx_val;
                        state    <= st_send_data;
                    end
                end
                st_send_data: begin
                    if (last_bit) begin
                        if (pending) begin
                            byte_cnt <= byte_cnt - 16'd1;
                            state    <= st_wait_edge;
                        end else if (gen_crc) begin
                            gen_crc <= 1'b0;
                            state   <= st_wait_edge;
                        end else begin
                            state <= st_ending;
                        end
                    end
                end
                default: begin
                    if (!cs) state <= st_idle;
                end
            endcase

            if (i_load) begin
                byte_cnt <= i_byte_count;
                gen_crc  <= i_gen_crc;
            end
        end
    end

    a_cs_busy: assert property (@(posedge i_clk) disable iff (!i_nrst)
        cs |-> (state != st_idle))
        else $error("spi_tx_shifter chip select active in idle");

endmodule

`default_nettype wire

//--- rtl/spi_clk_div.sv
//////////////////////////////
// SCLK divider
// level toggles every scaler cycles,
// with a strobe on each toggle
//////////////////////////////
`default_nettype none

module spi_clk_div (
    input  wire logic        i_clk,
    input  wire logic        i_nrst,
    input  wire logic [31:0] i_scaler,
    input  wire logic        i_restart,
    output logic             o_level,
    output logic             o_rise,
    output logic             o_fall
);

    logic [31:0] cnt;
    logic        level;
    logic        tick;

    // zero scaler stops the clock
    assign tick    = (i_scaler != '0) && (cnt == i_scaler - 32'd1);
    assign o_rise  = tick && !level;
    assign o_fall  = tick && level;
    assign o_level = level;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt   <= '0;
            level <= 1'b1;        // idle high so the first toggle is a fall
        end else begin
            if (i_restart || tick) cnt <= '0;
            else cnt <= cnt + 32'd1;
            if (tick) level <= !level;
        end
    end

    // restart comes with every new scaler value
    a_cnt_range: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_scaler != '0) |-> (cnt < i_scaler))
        else $error("spi_clk_div counter beyond the scaler");

endmodule

`default_nettype wire

//--- rtl/byte_fifo.sv
//////////////////////////////
// byte FIFO
// circular buffer, head always visible,
// occupancy count one bit wider than the pointers
//////////////////////////////
`default_nettype none

module byte_fifo #(
    parameter int log2_fifosz = spi_pkg::log2_fifosz_def
) (
    input  wire logic                 i_clk,
    input  wire logic                 i_nrst,
    input  wire logic                 i_we,
    input  wire logic [7:0]           i_wdata,
    input  wire logic                 i_re,
    output logic      [7:0]           o_rdata,
    output logic      [log2_fifosz:0] o_count
);

    localparam int depth = 2 ** log2_fifosz;

    logic [7:0]             mem [depth];
    logic [log2_fifosz-1:0] wr_ptr;
    logic [log2_fifosz-1:0] rd_ptr;
    logic [log2_fifosz:0]   count;
    logic                   do_rd;

    assign do_rd   = i_re && (count != '0);   // pop of empty is dropped
    assign o_rdata = mem[rd_ptr];
    assign o_count = count;

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_we) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({i_we, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(i_we && count[log2_fifosz]))
        else $error("byte_fifo written while full");

endmodule

`default_nettype wire

//--- rtl/spi_pkg.sv
//////////////////////////////
// SD card SPI master definitions
// register map, transmitter states
// and the control word layout
//////////////////////////////
`default_nettype none

package spi_pkg;

    localparam int log2_fifosz_def = 4;     // 16 entries per FIFO

    // word indices of the byte offsets 0x00, 0x44, 0x48, 0x4C, 0x58
    localparam logic [9:0] addr_sckdiv = 10'h000;
    localparam logic [9:0] addr_ctrl   = 10'h011;
    localparam logic [9:0] addr_txdata = 10'h012;
    localparam logic [9:0] addr_rxdata = 10'h013;
    localparam logic [9:0] addr_crc16  = 10'h016;

    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_wait_edge = 2'd1,
        st_send_data = 2'd2,
        st_ending    = 2'd3
    } spi_state_e;

    typedef struct packed {
        logic [15:0] byte_count;
        logic [7:0]  rsv_hi;
        logic        gen_crc;
        logic [6:0]  rsv_lo;
    } spi_ctrl_wr_t;

    // status view of the same register
    typedef struct packed {
        logic [15:0] byte_count;
        logic [7:0]  rsv_hi;
        logic        gen_crc;
        logic        rsv_6;
        spi_state_e  state;
        logic        rsv_3;
        logic        miso;
        logic        protect;
        logic        detected;
    } spi_ctrl_rd_t;

    typedef union packed {
        spi_ctrl_wr_t wr;
        spi_ctrl_rd_t rd;
    } spi_ctrl_word_u;

endpackage

`default_nettype wire
